//--- verilog/acq_params.svh
/* acquisition controller parameters */

`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

//////////////////////////////////////////////////
// datapath widths

`define ACQ_REG_W    32    // one configuration register
`define ACQ_ADDR_W   7     // register address in the command byte
`define ACQ_COUNT_W  24    // precharge and aperture counters

//////////////////////////////////////////////////
// acquisition sequence

// one entry is az-mux in the upper 4 bits, pc_sw in the low 2
`define ACQ_SEQ_W    6
`define ACQ_SEQ_N    4     // entries available to the sequencer

//////////////////////////////////////////////////
// status and pattern

`define ACQ_STATUS_MAGIC   8'b10101010   // fixed low byte of status
`define ACQ_PATTERN_SHIFT  4             // slows the test pattern down

//////////////////////////////////////////////////
// spi framing

// command byte plus one data word
`define ACQ_CMD_BITS   8
`define ACQ_FRAME_BITS 40

`endif

//--- verilog/acq_pkg.sv
/* acquisition controller types */

`include "acq_params.svh"

package acq_pkg;

  // alternate function select, other codes give all outputs low
  typedef enum logic [2:0] {
    MODE_DIRECT   = 3'd0,   // outputs straight from direct register
    MODE_PATTERN  = 3'd3,   // free running count, board bring-up
    MODE_SEQ_MOCK = 3'd6    // sequencer with mocked adc
  } mode_e;

  typedef enum logic [`ACQ_ADDR_W-1:0] {
    REG_MODE      = 7'd1,
    REG_DIRECT    = 7'd2,
    REG_STATUS    = 7'd3,   // read only
    REG_APERTURE  = 7'd4,
    REG_PRECHARGE = 7'd5,
    REG_SEQ_N     = 7'd6,
    REG_SEQ0      = 7'd7,
    REG_SEQ1      = 7'd8,
    REG_SEQ2      = 7'd9,
    REG_SEQ3      = 7'd10
  } reg_addr_e;

  // board control outputs, msb first, same order as direct register
  typedef struct packed {
    logic       meas_complete;
    logic       spi_interrupt;
    logic       adc_cmpr_latch;
    logic [3:0] adc_refmux;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } out_bundle_t;

endpackage

//--- verilog/spi_reg_bank.sv
/* oversampled spi register bank */

`timescale 1ns/1ns
`include "acq_params.svh"

module spi_reg_bank (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  sck_i,
  input  logic                                  ss_i,
  input  logic                                  sdi_i,
  output logic                                  sdo_o,
  input  logic [3:0]                            hw_flags_i,
  output acq_pkg::mode_e                        mode_o,
  output logic [`ACQ_REG_W-1:0]                 direct_o,
  output logic [`ACQ_COUNT_W-1:0]               aperture_o,
  output logic [`ACQ_COUNT_W-1:0]               precharge_o,
  output logic [1:0]                            seq_n_o,
  output logic [`ACQ_SEQ_N-1:0][`ACQ_SEQ_W-1:0] seq_entries_o
);

  localparam logic [5:0] CMD_LAST   = 6'(`ACQ_CMD_BITS);
  localparam logic [5:0] FRAME_LAST = 6'(`ACQ_FRAME_BITS);

  //////////////////////////////////////////////////
  // pin synchronizers and edge detect

  logic [1:0] sck_q, ss_q, sdi_q;   // two flops each
  logic       sck_d, ss_d;          // previous synced value

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sck_q <= '0;
      ss_q  <= 2'b11;               // deselected
      sdi_q <= '0;
      sck_d <= 1'b0;
      ss_d  <= 1'b1;
    end else begin
      sck_q <= {sck_q[0], sck_i};
      ss_q  <= {ss_q[0], ss_i};
      sdi_q <= {sdi_q[0], sdi_i};
      sck_d <= sck_q[1];
      ss_d  <= ss_q[1];
    end
  end

  logic sck_rise, sck_fall, ss_rise, selected;
  assign sck_rise = sck_q[1] & ~sck_d;
  assign sck_fall = ~sck_q[1] & sck_d;
  assign ss_rise  = ss_q[1] & ~ss_d;   // frame end
  assign selected = ~ss_q[1];

  //////////////////////////////////////////////////
  // shift in, shift out

  logic [5:0]                  bit_cnt;   // saturating count of sck rises
  logic [`ACQ_FRAME_BITS-1:0]  rx_sr;
  logic [`ACQ_FRAME_BITS-1:0]  rx_next;
  logic [`ACQ_REG_W-1:0]       tx_sr;     // readback word
  logic [`ACQ_REG_W-1:0]       rd_data;
  logic                        sdo_q;

  assign rx_next = {rx_sr[`ACQ_FRAME_BITS-2:0], sdi_q[1]};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bit_cnt <= '0;
      sdo_q   <= 1'b0;
    end else if (!selected) begin
      bit_cnt <= '0;
      sdo_q   <= 1'b0;
    end else begin
      if (sck_rise && bit_cnt != '1)
        bit_cnt <= bit_cnt + 6'd1;
      // data bits change after each falling edge
      if (sck_fall && bit_cnt >= CMD_LAST && bit_cnt < FRAME_LAST)
        sdo_q <= tx_sr[`ACQ_REG_W-1];
    end
  end

  // shift registers on sck edges
  always_ff @(posedge clk_i) begin
    if (selected && sck_rise)
      rx_sr <= rx_next;
    if (selected && sck_rise && bit_cnt == CMD_LAST - 6'd1)
      tx_sr <= rd_data;                     // command byte just completed
    else if (selected && sck_fall && bit_cnt >= CMD_LAST)
      tx_sr <= {tx_sr[`ACQ_REG_W-2:0], 1'b0};
  end

  assign sdo_o = sdo_q;

  //////////////////////////////////////////////////
  // configuration registers

  logic [2:0]                            mode_q;
  logic [`ACQ_REG_W-1:0]                 direct_q;
  logic [`ACQ_COUNT_W-1:0]               aperture_q, precharge_q;
  logic [1:0]                            seq_n_q;
  logic [`ACQ_SEQ_N-1:0][`ACQ_SEQ_W-1:0] seq_q;

  // readback select from the command byte now completing
  always_comb begin
    rd_data = '0;                           // unknown addresses read zero
    case (acq_pkg::reg_addr_e'(rx_next[`ACQ_ADDR_W-1:0]))
      acq_pkg::REG_MODE:      rd_data[2:0] = mode_q;
      acq_pkg::REG_DIRECT:    rd_data = direct_q;
      acq_pkg::REG_STATUS:    rd_data[11:0] = {hw_flags_i, `ACQ_STATUS_MAGIC};
      acq_pkg::REG_APERTURE:  rd_data[`ACQ_COUNT_W-1:0] = aperture_q;
      acq_pkg::REG_PRECHARGE: rd_data[`ACQ_COUNT_W-1:0] = precharge_q;
      acq_pkg::REG_SEQ_N:     rd_data[1:0] = seq_n_q;
      acq_pkg::REG_SEQ0:      rd_data[`ACQ_SEQ_W-1:0] = seq_q[0];
      acq_pkg::REG_SEQ1:      rd_data[`ACQ_SEQ_W-1:0] = seq_q[1];
      acq_pkg::REG_SEQ2:      rd_data[`ACQ_SEQ_W-1:0] = seq_q[2];
      acq_pkg::REG_SEQ3:      rd_data[`ACQ_SEQ_W-1:0] = seq_q[3];
      default:                rd_data = '0;
    endcase
  end

  // frame layout  {wr, addr[6:0], data[31:0]}
  logic                    wr_en;
  logic [`ACQ_REG_W-1:0]   wr_data;
  assign wr_en   = ss_rise && bit_cnt == FRAME_LAST && rx_sr[`ACQ_FRAME_BITS-1];
  assign wr_data = rx_sr[`ACQ_REG_W-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_q      <= '0;
      direct_q    <= '0;
      aperture_q  <= '0;
      precharge_q <= '0;
      seq_n_q     <= '0;
      seq_q       <= '0;
    end else if (wr_en) begin
      case (acq_pkg::reg_addr_e'(rx_sr[`ACQ_REG_W +: `ACQ_ADDR_W]))
        acq_pkg::REG_MODE:      mode_q      <= wr_data[2:0];
        acq_pkg::REG_DIRECT:    direct_q    <= wr_data;
        acq_pkg::REG_APERTURE:  aperture_q  <= wr_data[`ACQ_COUNT_W-1:0];
        acq_pkg::REG_PRECHARGE: precharge_q <= wr_data[`ACQ_COUNT_W-1:0];
        acq_pkg::REG_SEQ_N:     seq_n_q     <= wr_data[1:0];
        acq_pkg::REG_SEQ0:      seq_q[0]    <= wr_data[`ACQ_SEQ_W-1:0];
        acq_pkg::REG_SEQ1:      seq_q[1]    <= wr_data[`ACQ_SEQ_W-1:0];
        acq_pkg::REG_SEQ2:      seq_q[2]    <= wr_data[`ACQ_SEQ_W-1:0];
        acq_pkg::REG_SEQ3:      seq_q[3]    <= wr_data[`ACQ_SEQ_W-1:0];
        default: ;                          // status and unknown ignored
      endcase
    end
  end

  assign mode_o        = acq_pkg::mode_e'(mode_q);
  assign direct_o      = direct_q;
  assign aperture_o    = aperture_q;
  assign precharge_o   = precharge_q;
  assign seq_n_o       = seq_n_q;
  assign seq_entries_o = seq_q;

endmodule

//--- verilog/seq_acquisition.sv
/* acquisition sequencer */

`timescale 1ns/1ns
`include "acq_params.svh"

module seq_acquisition (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  run_i,
  input  logic                                  measure_valid_i,
  input  logic [1:0]                            seq_n_i,
  input  logic [`ACQ_SEQ_N-1:0][`ACQ_SEQ_W-1:0] seq_entries_i,
  input  logic [`ACQ_COUNT_W-1:0]               precharge_i,
  output logic [3:0]                            azmux_o,
  output logic [1:0]                            pc_sw_o,
  output logic                                  adc_reset_n_o,
  output logic [1:0]                            status_last_o,
  output logic [3:0]                            leds_o,
  output logic [7:0]                            monitor_o
);

  // state code is shown on the monitor
  typedef enum logic [1:0] {
    S_IDLE      = 2'd0,
    S_PRECHARGE = 2'd1,   // adc held in reset
    S_MEASURE   = 2'd2    // adc released, wait for valid
  } state_e;

  state_e                  state;
  logic [1:0]              idx;          // current entry
  logic [`ACQ_COUNT_W-1:0] pc_cnt;
  logic                    adc_reset_n;
  logic [1:0]              status_last;

  //////////////////////////////////////////////////
  // precharge / measure fsm

  always_ff @(posedge clk_i) begin
    if (reset_i || !run_i) begin
      state       <= S_IDLE;
      idx         <= '0;                 // back to first entry
      pc_cnt      <= '0;
      adc_reset_n <= 1'b0;
      if (reset_i)
        status_last <= '0;               // keep last result across a stop
    end else begin
      case (state)
        S_IDLE: begin
          state       <= S_PRECHARGE;
          pc_cnt      <= `ACQ_COUNT_W'(1);
          adc_reset_n <= 1'b0;
        end
        S_PRECHARGE: begin
          if (pc_cnt >= precharge_i) begin
            state       <= S_MEASURE;
            adc_reset_n <= 1'b1;         // let the adc start
          end else begin
            pc_cnt <= pc_cnt + `ACQ_COUNT_W'(1);
          end
        end
        S_MEASURE: begin
          if (measure_valid_i) begin
            status_last <= idx;          // entry just measured
            idx         <= (idx == seq_n_i) ? 2'd0 : idx + 2'd1;
            state       <= S_PRECHARGE;
            pc_cnt      <= `ACQ_COUNT_W'(1);
            adc_reset_n <= 1'b0;
          end
        end
        default: begin
          state       <= S_IDLE;
          adc_reset_n <= 1'b0;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // outputs

  logic [`ACQ_SEQ_W-1:0] entry;
  assign entry = seq_entries_i[idx];

  assign azmux_o       = entry[`ACQ_SEQ_W-1 -: 4];   // upper nibble
  assign pc_sw_o       = entry[1:0];
  assign adc_reset_n_o = adc_reset_n;
  assign status_last_o = status_last;
  assign leds_o        = 4'b0001 << idx;            // one-hot entry

  assign monitor_o = {
    adc_reset_n,      // 7
    measure_valid_i,  // 6
    state,            // 5:4
    idx,              // 3:2
    status_last       // 1:0
  };

endmodule

//--- verilog/adc_mock.sv
/* mock adc */

`timescale 1ns/1ns
`include "acq_params.svh"

module adc_mock (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    adc_reset_n_i,
  input  logic [`ACQ_COUNT_W-1:0] aperture_i,
  output logic                    measure_valid_o
);

  logic [`ACQ_COUNT_W-1:0] cnt;       // cycles since release
  logic [`ACQ_COUNT_W-1:0] cnt_next;
  logic                    done;      // one pulse per release
  logic                    valid;

  assign cnt_next = cnt + `ACQ_COUNT_W'(1);

  always_ff @(posedge clk_i) begin
    if (reset_i || !adc_reset_n_i) begin
      cnt   <= '0;
      done  <= 1'b0;
      valid <= 1'b0;
    end else if (!done) begin
      cnt <= cnt_next;
      // valid lands aperture cycles after first released cycle
      if (cnt_next >= aperture_i) begin
        valid <= 1'b1;
        done  <= 1'b1;
      end
    end else begin
      valid <= 1'b0;                  // idle until next reset
    end
  end

  assign measure_valid_o = valid;

endmodule

//--- verilog/output_mode_mux.sv
/* output mode mux */

`timescale 1ns/1ns
`include "acq_params.svh"

module output_mode_mux (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  acq_pkg::mode_e       mode_i,
  input  logic [`ACQ_REG_W-1:0] direct_i,
  input  logic [3:0]           seq_azmux_i,
  input  logic [1:0]           seq_pc_sw_i,
  input  logic [3:0]           seq_leds_i,
  input  logic [7:0]           seq_monitor_i,
  output acq_pkg::out_bundle_t outputs_o
);

  localparam int BUNDLE_W = $bits(acq_pkg::out_bundle_t);

  //////////////////////////////////////////////////
  // test pattern

  logic [31:0] pattern_cnt;
  logic [31:0] pattern;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      pattern_cnt <= '0;
    else
      pattern_cnt <= pattern_cnt + 32'd1;   // free running
  end

  assign pattern = pattern_cnt >> `ACQ_PATTERN_SHIFT;

  //////////////////////////////////////////////////
  // source select

  acq_pkg::out_bundle_t sel;

  always_comb begin
    sel = '0;                                // unused modes drive low
    case (mode_i)
      acq_pkg::MODE_DIRECT:  sel = acq_pkg::out_bundle_t'(direct_i[BUNDLE_W-1:0]);
      acq_pkg::MODE_PATTERN: sel = acq_pkg::out_bundle_t'(pattern[BUNDLE_W-1:0]);
      acq_pkg::MODE_SEQ_MOCK: begin
        sel.azmux   = seq_azmux_i;
        sel.pc_sw   = seq_pc_sw_i;
        sel.monitor = seq_monitor_i;
        sel.leds    = seq_leds_i;
      end
      default: sel = '0;
    endcase
  end

  // outputs one cycle behind the select
  always_ff @(posedge clk_i) begin
    if (reset_i)
      outputs_o <= '0;
    else
      outputs_o <= sel;
  end

endmodule

//--- verilog/acq_top.sv
/* adc board controller top */

`timescale 1ns/1ns
`include "acq_params.svh"

module acq_top (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       sck_i,
  input  logic       ss_i,
  input  logic       sdi_i,
  output logic       sdo_o,
  input  logic [3:0] hw_flags_i,
  input  logic       trigger_internal_i,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [3:0] adc_refmux_o,
  output logic       adc_cmpr_latch_ctl_o,
  output logic       spi_interrupt_ctl_o,
  output logic       meas_complete_o
);

  //////////////////////////////////////////////////
  // register bank

  acq_pkg::mode_e                        mode;
  logic [`ACQ_REG_W-1:0]                 direct;
  logic [`ACQ_COUNT_W-1:0]               aperture, precharge;
  logic [1:0]                            seq_n;
  logic [`ACQ_SEQ_N-1:0][`ACQ_SEQ_W-1:0] seq_entries;

  spi_reg_bank u_regs (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .sck_i         (sck_i),
    .ss_i          (ss_i),
    .sdi_i         (sdi_i),
    .sdo_o         (sdo_o),
    .hw_flags_i    (hw_flags_i),
    .mode_o        (mode),
    .direct_o      (direct),
    .aperture_o    (aperture),
    .precharge_o   (precharge),
    .seq_n_o       (seq_n),
    .seq_entries_o (seq_entries)
  );

  //////////////////////////////////////////////////
  // sequencer against mocked adc

  logic       adc_reset_n, measure_valid;
  logic [3:0] seq_azmux, seq_leds;
  logic [1:0] seq_pc_sw;
  logic [7:0] seq_monitor;

  seq_acquisition u_seq (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .run_i           (trigger_internal_i),   // trigger gates the run
    .measure_valid_i (measure_valid),
    .seq_n_i         (seq_n),
    .seq_entries_i   (seq_entries),
    .precharge_i     (precharge),
    .azmux_o         (seq_azmux),
    .pc_sw_o         (seq_pc_sw),
    .adc_reset_n_o   (adc_reset_n),
    .status_last_o   (),                     // only seen on monitor here
    .leds_o          (seq_leds),
    .monitor_o       (seq_monitor)
  );

  adc_mock u_adc (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .adc_reset_n_i   (adc_reset_n),
    .aperture_i      (aperture),
    .measure_valid_o (measure_valid)
  );

  //////////////////////////////////////////////////
  // alternate function select

  acq_pkg::out_bundle_t outs;

  output_mode_mux u_mux (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mode_i        (mode),
    .direct_i      (direct),
    .seq_azmux_i   (seq_azmux),
    .seq_pc_sw_i   (seq_pc_sw),
    .seq_leds_i    (seq_leds),
    .seq_monitor_i (seq_monitor),
    .outputs_o     (outs)
  );

  // bundle onto pins
  assign meas_complete_o      = outs.meas_complete;
  assign spi_interrupt_ctl_o  = outs.spi_interrupt;
  assign adc_cmpr_latch_ctl_o = outs.adc_cmpr_latch;
  assign adc_refmux_o         = outs.adc_refmux;
  assign azmux_o              = outs.azmux;
  assign pc_sw_o              = outs.pc_sw;
  assign monitor_o            = outs.monitor;
  assign leds_o               = outs.leds;

endmodule

//--- testbench/tb_acq_top.sv
/* acquisition controller testbench */

`timescale 1ns/1ns
`include "acq_params.svh"

module tb_acq_top;

  localparam int SCK_HALF    = 4;     // clk cycles per sck phase
  localparam int SEQ_TIMEOUT = 200;   // cycles allowed per entry change
  localparam int MIN_HOLD    = 50;

  logic       clk, reset, sck, ss, sdi, sdo, trigger;
  logic [3:0] hw_flags, leds;
  logic [7:0] monitor;
  logic [1:0] pc_sw;
  logic [3:0] azmux, adc_refmux;
  logic       adc_cmpr_latch, spi_interrupt, meas_complete;

  integer     seed;
  int         mismatch_cnt, other_cnt;
  logic       seq_watch;              // sequencer phase with entry 3 banned
  logic [5:0] entries [4];

  acq_top dut (
    .clk_i                (clk),
    .reset_i              (reset),
    .sck_i                (sck),
    .ss_i                 (ss),
    .sdi_i                (sdi),
    .sdo_o                (sdo),
    .hw_flags_i           (hw_flags),
    .trigger_internal_i   (trigger),
    .leds_o               (leds),
    .monitor_o            (monitor),
    .pc_sw_o              (pc_sw),
    .azmux_o              (azmux),
    .adc_refmux_o         (adc_refmux),
    .adc_cmpr_latch_ctl_o (adc_cmpr_latch),
    .spi_interrupt_ctl_o  (spi_interrupt),
    .meas_complete_o      (meas_complete)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;            // 4 ns period
  end

  //////////////////////////////////////////////////
  // helpers

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;                               // drive point after the edge
  endtask

  task automatic end_run;
    $display("error counts: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    other_cnt++;
    $display("timeout at %0t ns while waiting for %s", $time, what);
    end_run();
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // one mode 0 frame of command byte then 32 data bits
  task automatic spi_frame(input logic wr, input logic [6:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {wr, addr, wdata};
    rdata = '0;
    ss    = 1'b0;
    for (int i = 39; i >= 0; i--) begin
      sdi = frame[i];
      wait_clks(SCK_HALF);
      if (i < 32)
        rdata[i] = sdo;               // settled during low phase
      sck = 1'b1;
      wait_clks(SCK_HALF);
      sck = 1'b0;
    end
    wait_clks(SCK_HALF);
    ss  = 1'b1;
    sdi = 1'b0;
    wait_clks(2 * SCK_HALF);          // write commits and reaches the pins here
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    spi_frame(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
    spi_frame(1'b0, addr, 32'h0, data);
  endtask

  // board pins in bundle order from msb
  function automatic logic [24:0] out_pins();
    return {meas_complete, spi_interrupt, adc_cmpr_latch, adc_refmux,
            azmux, pc_sw, monitor, leds};
  endfunction

  // waits for the az-mux/pc_sw pair to leave old and counts hold cycles
  task automatic wait_pair_change(input logic [5:0] old, input int k, output int held);
    held = 0;
    while ({azmux, pc_sw} == old && held < SEQ_TIMEOUT) begin
      check_eq("leds_o", 32'(4'b0001 << k), 32'(leds));   // one-hot entry
      wait_clks(1);
      held++;
    end
    if ({azmux, pc_sw} == old)
      report_timeout("sequencer entry change");
  endtask

  //////////////////////////////////////////////////
  // entry 3 lies past seq_n and must never show

  always @(negedge clk) begin
    if (seq_watch) begin
      assert ({azmux, pc_sw} != entries[3] && leds != 4'b1000) else begin
        other_cnt++;
        $display("sequencer showed entry 3 at %0t ns", $time);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  initial begin
    logic [31:0] rd, val, status_exp;
    logic [3:0]  prev;
    logic [3:0]  exp_leds;
    logic [5:0]  exp_pair;
    logic        fresh;
    int          n, held;
    int          visit [4];
    seed         = 80086;
    mismatch_cnt = 0;
    other_cnt    = 0;
    seq_watch    = 1'b0;
    reset        = 1'b1;
    sck          = 1'b0;
    ss           = 1'b1;              // deselected
    sdi          = 1'b0;
    hw_flags     = 4'h0;
    trigger      = 1'b0;
    visit        = '{0, 1, 2, 0};
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;

    // reset state before any write
    check_eq("outputs", 32'h0, 32'(out_pins()));
    check_eq("sdo_o", 32'h0, 32'(sdo));

    // status readback before and after a write attempt
    hw_flags = 4'($random(seed));
    while (hw_flags == 4'h0)
      hw_flags = 4'($random(seed));   // flags must show in the word
    status_exp = {20'h0, hw_flags, `ACQ_STATUS_MAGIC};
    read_reg(acq_pkg::REG_STATUS, rd);
    check_eq("status", status_exp, rd);
    write_reg(acq_pkg::REG_STATUS, $random(seed));
    read_reg(acq_pkg::REG_STATUS, rd);
    check_eq("status after write", status_exp, rd);

    // aperture keeps 24 bits and unknown address reads zero
    val = $random(seed);
    write_reg(acq_pkg::REG_APERTURE, val);
    read_reg(acq_pkg::REG_APERTURE, rd);
    check_eq("aperture", {8'h0, val[23:0]}, rd);
    read_reg(7'h55, rd);
    check_eq("unknown address", 32'h0, rd);

    //////////////////////////////////////////////////
    // direct mode

    val = $random(seed);
    write_reg(acq_pkg::REG_MODE, 32'(acq_pkg::MODE_DIRECT));
    write_reg(acq_pkg::REG_DIRECT, val);
    n = 0;
    while (n < 10 && out_pins() != val[24:0]) begin   // bounded settle
      wait_clks(1);
      n++;
    end
    check_eq("leds_o", 32'(val[3:0]), 32'(leds));
    check_eq("monitor_o", 32'(val[11:4]), 32'(monitor));
    check_eq("pc_sw_o", 32'(val[13:12]), 32'(pc_sw));
    check_eq("azmux_o", 32'(val[17:14]), 32'(azmux));
    check_eq("adc_refmux_o", 32'(val[21:18]), 32'(adc_refmux));
    check_eq("adc_cmpr_latch_ctl_o", 32'(val[22]), 32'(adc_cmpr_latch));
    check_eq("spi_interrupt_ctl_o", 32'(val[23]), 32'(spi_interrupt));
    check_eq("meas_complete_o", 32'(val[24]), 32'(meas_complete));

    // pattern mode steps leds once per 2^shift cycles
    write_reg(acq_pkg::REG_MODE, 32'(acq_pkg::MODE_PATTERN));
    prev = leds;
    for (int i = 0; i < 20; i++) begin   // runs past the wrap
      wait_clks(1 << `ACQ_PATTERN_SHIFT);
      exp_leds = prev + 4'd1;            // modulo 16
      check_eq("leds_o", 32'(exp_leds), 32'(leds));
      prev = leds;
    end

    //////////////////////////////////////////////////
    // sequencer with mocked adc

    for (int k = 0; k < 4; k++) begin
      fresh = 1'b0;
      while (!fresh) begin
        entries[k] = 6'($random(seed));
        fresh      = 1'b1;
        for (int j = 0; j < k; j++)
          if (entries[k] == entries[j])
            fresh = 1'b0;             // all four entries distinct
      end
    end
    for (int k = 0; k < 4; k++)
      write_reg(7'(acq_pkg::REG_SEQ0 + k), 32'(entries[k]));
    write_reg(acq_pkg::REG_SEQ_N, 32'd2);
    write_reg(acq_pkg::REG_PRECHARGE, 32'd20);
    write_reg(acq_pkg::REG_APERTURE, 32'd30);
    write_reg(acq_pkg::REG_MODE, 32'(acq_pkg::MODE_SEQ_MOCK));
    check_eq("azmux_o/pc_sw_o", 32'(entries[0]), 32'({azmux, pc_sw}));
    seq_watch = 1'b1;
    trigger   = 1'b1;
    for (int v = 0; v < 3; v++) begin
      wait_pair_change(entries[visit[v]], visit[v], held);
      assert (held >= MIN_HOLD) else begin
        other_cnt++;
        $display("entry %0d held only %0d cycles, fewer than %0d", visit[v], held, MIN_HOLD);
      end
      exp_pair = entries[visit[v + 1]];
      check_eq("azmux_o/pc_sw_o", 32'(exp_pair), 32'({azmux, pc_sw}));
    end
    wait_clks(2);
    seq_watch = 1'b0;
    trigger   = 1'b0;
    end_run();
  end

endmodule

//--- sim.f
+incdir+verilog
verilog/acq_pkg.sv
verilog/spi_reg_bank.sv
verilog/seq_acquisition.sv
verilog/adc_mock.sv
verilog/output_mode_mux.sv
verilog/acq_top.sv
testbench/tb_acq_top.sv

//--- Bender.yml
package:
  name: acq_ctrl

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/acq_pkg.sv
      - verilog/spi_reg_bank.sv
      - verilog/seq_acquisition.sv
      - verilog/adc_mock.sv
      - verilog/output_mode_mux.sv
      - verilog/acq_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_acq_top.sv
